//--- regctl.f
+incdir+.
regctl_pkg.sv
event_counter.sv
reg_bank.sv
axil_regctl.sv
regctl_top.sv
tb_regctl.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = -sv --timing --assert
TOP       = tb_regctl
FILELIST  = regctl.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// move to 1 ns after the next rising edge, where inputs change
task automatic next_cycle();
	@(posedge clk);
	#1;
endtask

// fair coin for the response ready lines
function automatic logic rand_bit();
	return $random(seed) % 2 != 0;
endfunction

// aw and w presented together, then the b response under random bready
task automatic axi_write(input axi_addr_t addr, input reg_data_t data);
	s_axi_awaddr = addr;
	s_axi_awvalid = 1'b1;
	s_axi_wdata = data;
	s_axi_wvalid = 1'b1;
	// readies seen now means the handshake happens at the coming edge
	do
		next_cycle();
	while (!(s_axi_awready && s_axi_wready));
	next_cycle();
	s_axi_awvalid = 1'b0;
	s_axi_wvalid = 1'b0;
	s_axi_bready = rand_bit();
	while (!(s_axi_bvalid && s_axi_bready)) begin
		next_cycle();
		s_axi_bready = rand_bit();
	end
	check_value(reg_data_t'(s_axi_bresp), reg_data_t'(RESP_OKAY), "bresp not OKAY");
	next_cycle();
	s_axi_bready = 1'b0;
endtask

// ar handshake, then r data taken under random rready
task automatic axi_read(input axi_addr_t addr, output reg_data_t data);
	s_axi_araddr = addr;
	s_axi_arvalid = 1'b1;
	do
		next_cycle();
	while (!s_axi_arready);
	next_cycle();
	s_axi_arvalid = 1'b0;
	s_axi_rready = rand_bit();
	while (!(s_axi_rvalid && s_axi_rready)) begin
		next_cycle();
		s_axi_rready = rand_bit();
	end
	// rdata is held by the register bank, stable here
	data = s_axi_rdata;
	check_value(reg_data_t'(s_axi_rresp), reg_data_t'(RESP_OKAY), "rresp not OKAY");
	next_cycle();
	s_axi_rready = 1'b0;
endtask

`endif

//--- tb_regctl.sv
`timescale 1ns/100ps

module tb_regctl;
	import regctl_pkg::*;

	// about 150 transactions of a few cycles each, ample margin
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int NUM_ROUNDS = 4;
	// random reads per round of scratch writes
	localparam int NUM_READS = 16;
	localparam int SW = $clog2(NUM_SCRATCH);

	logic clk;
	logic resetn;
	axi_addr_t s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	reg_data_t s_axi_wdata;
	logic s_axi_wvalid;
	logic s_axi_wready;
	axi_resp_t s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	axi_addr_t s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	reg_data_t s_axi_rdata;
	axi_resp_t s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;

	int seed = 97;
	int num_checks = 0;
	int num_errors = 0;
	int cycle_count = 0;
	// shadow copy of the writable registers
	reg_data_t shadow_scratch [NUM_SCRATCH];
	logic shadow_ctrl;
	reg_data_t got;
	reg_data_t first;
	reg_data_t data;
	reg_idx_t idx;
	reg_data_t preset;

	regctl_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input reg_data_t actual, input reg_data_t expected,
			input string what);
		num_checks++;
		if (actual !== expected) begin
			num_errors++;
			$display("mismatch at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
		end
	endtask

	// expected word for a register read, from the register map rules
	function automatic reg_data_t expected_read(input reg_idx_t ridx, input logic ctrl,
			input reg_data_t scr [NUM_SCRATCH]);
		reg_data_t word;
		int off;
		word = '0;
		off = int'(ridx) - int'(REG_SCRATCH_BASE);
		if (ridx == REG_ID)
			word = ID_VALUE;
		else if (ridx == REG_CTRL)
			word[0] = ctrl;
		else if (off >= 0 && off < NUM_SCRATCH)
			word = scr[off[SW-1:0]];
		// unmapped words keep the zero default
		// the counter value is not modelled
		return word;
	endfunction

	function automatic axi_addr_t word_addr(input reg_idx_t ridx);
		return {ridx, 2'b00};
	endfunction

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	`include "tb_axil_tasks.svh"

	// hang guard
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: no completion after %0d cycles, a transaction is stuck",
				cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		resetn = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		shadow_ctrl = 1'b0;
		for (int i = 0; i < NUM_SCRATCH; i++)
			shadow_scratch[i[SW-1:0]] = '0;
		repeat (8) @(posedge clk);
		#1;
		resetn = 1'b1;

		// values straight after reset
		axi_read(word_addr(REG_ID), got);
		check_value(got, ID_VALUE, "id after reset");
		axi_read(word_addr(REG_CTRL), got);
		check_value(got, expected_read(REG_CTRL, shadow_ctrl, shadow_scratch), "ctrl after reset");
		axi_read(word_addr(REG_COUNT), got);
		check_value(got, '0, "count after reset");

		// scratch words, read back in random order
		for (int r = 0; r < NUM_ROUNDS; r++) begin
			for (int i = 0; i < NUM_SCRATCH; i++) begin
				data = reg_data_t'($random(seed));
				axi_write(word_addr(reg_idx_t'(int'(REG_SCRATCH_BASE) + i)), data);
				shadow_scratch[i[SW-1:0]] = data;
			end
			for (int n = 0; n < NUM_READS; n++) begin
				idx = reg_idx_t'(int'(REG_SCRATCH_BASE) + rand_below(NUM_SCRATCH));
				axi_read(word_addr(idx), got);
				check_value(got, expected_read(idx, shadow_ctrl, shadow_scratch), "scratch readback");
			end
		end

		// id is read only, unmapped words read zero and hold nothing
		axi_write(word_addr(REG_ID), 32'hdead_beef);
		axi_write(word_addr(8'd3), reg_data_t'($random(seed)));
		axi_write(word_addr(8'd200), reg_data_t'($random(seed)));
		axi_read(word_addr(8'd3), got);
		check_value(got, '0, "unmapped index 3");
		axi_read(word_addr(8'd200), got);
		check_value(got, '0, "unmapped index 200");
		for (int i = 0; i < int'(REG_SCRATCH_BASE) + NUM_SCRATCH; i++) begin
			if (i != int'(REG_COUNT)) begin
				axi_read(word_addr(reg_idx_t'(i)), got);
				check_value(got, expected_read(reg_idx_t'(i), shadow_ctrl, shadow_scratch),
					"register after unmapped writes");
			end
		end
		axi_read(word_addr(REG_COUNT), got);
		check_value(got, '0, "count after unmapped writes");

		// preset while disabled stays put
		preset = 32'h1000_0000;
		axi_write(word_addr(REG_COUNT), preset);
		axi_read(word_addr(REG_COUNT), got);
		check_value(got, preset, "count after preset");
		axi_read(word_addr(REG_COUNT), got);
		check_value(got, preset, "count still at preset");

		// enabled counter keeps moving up
		axi_write(word_addr(REG_CTRL), 32'd1);
		shadow_ctrl = 1'b1;
		axi_read(word_addr(REG_CTRL), got);
		check_value(got, expected_read(REG_CTRL, shadow_ctrl, shadow_scratch), "ctrl enabled");
		axi_read(word_addr(REG_COUNT), first);
		check_value(reg_data_t'(first > preset), 32'd1, "count above preset");
		axi_read(word_addr(REG_COUNT), got);
		check_value(reg_data_t'(got > first), 32'd1, "count still increasing");

		// disabled again, counter frozen
		axi_write(word_addr(REG_CTRL), 32'd0);
		shadow_ctrl = 1'b0;
		axi_read(word_addr(REG_COUNT), first);
		axi_read(word_addr(REG_COUNT), got);
		check_value(got, first, "count frozen after disable");

		$display("checks: %0d, errors: %0d", num_checks, num_errors);
		if (num_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- regctl_top.sv
`timescale 1ns/100ps

module regctl_top (
	input  logic                  clk,
	input  logic                  resetn,
	input  regctl_pkg::axi_addr_t s_axi_awaddr,
	input  logic                  s_axi_awvalid,
	output logic                  s_axi_awready,
	input  regctl_pkg::reg_data_t s_axi_wdata,
	input  logic                  s_axi_wvalid,
	output logic                  s_axi_wready,
	output regctl_pkg::axi_resp_t s_axi_bresp,
	output logic                  s_axi_bvalid,
	input  logic                  s_axi_bready,
	input  regctl_pkg::axi_addr_t s_axi_araddr,
	input  logic                  s_axi_arvalid,
	output logic                  s_axi_arready,
	output regctl_pkg::reg_data_t s_axi_rdata,
	output regctl_pkg::axi_resp_t s_axi_rresp,
	output logic                  s_axi_rvalid,
	input  logic                  s_axi_rready
);
	import regctl_pkg::*;

	// bridge to register bank
	logic rd_en;
	reg_idx_t rd_idx;
	reg_data_t rd_data;
	logic wr_en;
	reg_idx_t wr_idx;
	reg_data_t wr_data;
	// register bank to counter
	logic count_en;
	logic load;
	reg_data_t load_value;
	reg_data_t count;

	axil_regctl i_axil_regctl (
		.clk           (clk),
		.resetn        (resetn),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.rd_en         (rd_en),
		.rd_idx        (rd_idx),
		.rd_data       (rd_data),
		.wr_en         (wr_en),
		.wr_idx        (wr_idx),
		.wr_data       (wr_data)
	);

	reg_bank i_reg_bank (
		.clk        (clk),
		.resetn     (resetn),
		.rd_en      (rd_en),
		.rd_idx     (rd_idx),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.wr_data    (wr_data),
		.rd_data    (rd_data),
		.count_en   (count_en),
		.load       (load),
		.load_value (load_value),
		.count      (count)
	);

	event_counter i_event_counter (
		.clk        (clk),
		.resetn     (resetn),
		.count_en   (count_en),
		.load       (load),
		.load_value (load_value),
		.count      (count)
	);

endmodule

//--- axil_regctl.sv
`timescale 1ns/100ps

module axil_regctl (
	input  logic                  clk,
	input  logic                  resetn,
	// write address channel
	input  regctl_pkg::axi_addr_t s_axi_awaddr,
	input  logic                  s_axi_awvalid,
	output logic                  s_axi_awready,
	// write data channel
	input  regctl_pkg::reg_data_t s_axi_wdata,
	input  logic                  s_axi_wvalid,
	output logic                  s_axi_wready,
	// write response channel
	output regctl_pkg::axi_resp_t s_axi_bresp,
	output logic                  s_axi_bvalid,
	input  logic                  s_axi_bready,
	// read address channel
	input  regctl_pkg::axi_addr_t s_axi_araddr,
	input  logic                  s_axi_arvalid,
	output logic                  s_axi_arready,
	// read data channel
	output regctl_pkg::reg_data_t s_axi_rdata,
	output regctl_pkg::axi_resp_t s_axi_rresp,
	output logic                  s_axi_rvalid,
	input  logic                  s_axi_rready,
	// register side strobes
	output logic                  rd_en,
	output regctl_pkg::reg_idx_t  rd_idx,
	input  regctl_pkg::reg_data_t rd_data,
	output logic                  wr_en,
	output regctl_pkg::reg_idx_t  wr_idx,
	output regctl_pkg::reg_data_t wr_data
);
	import regctl_pkg::*;

	// write address held from acceptance until the strobe
	axi_addr_t aw_addr_q;
	// high while no write response is outstanding
	logic aw_en;
	// awready and wready always move together
	logic wr_ready_q;
	logic bvalid_q;
	logic arready_q;
	logic rvalid_q;
	logic wr_accept;
	logic rd_accept;

	// both aw and w present and the previous response is gone
	assign wr_accept = ~wr_ready_q && s_axi_awvalid && s_axi_wvalid && aw_en;
	// no new read while read data still waits for rready
	assign rd_accept = ~arready_q && s_axi_arvalid && ~rvalid_q;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ready_q <= 1'b0;
			aw_en <= 1'b1;
		end else if (wr_accept) begin
			wr_ready_q <= 1'b1;
			aw_en <= 1'b0;
		end else begin
			// ready is a single cycle pulse
			wr_ready_q <= 1'b0;
			// reopen for the next write after the b handshake
			if (bvalid_q && s_axi_bready)
				aw_en <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_accept)
			aw_addr_q <= s_axi_awaddr;
	end

	// strobe in the cycle both readies are up
	assign wr_en = wr_ready_q && s_axi_awvalid && s_axi_wvalid;
	assign wr_idx = aw_addr_q[ADDR_W-1 -: IDX_W];
	// master holds wdata until wready, so no copy is needed
	assign wr_data = s_axi_wdata;

	always_ff @(posedge clk) begin
		if (!resetn)
			bvalid_q <= 1'b0;
		else if (wr_en && !bvalid_q)
			bvalid_q <= 1'b1;
		else if (s_axi_bready)
			bvalid_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			arready_q <= 1'b0;
		else
			arready_q <= rd_accept;
	end

	// araddr is still stable during the arready cycle
	assign rd_en = arready_q && s_axi_arvalid && ~rvalid_q;
	assign rd_idx = s_axi_araddr[ADDR_W-1 -: IDX_W];

	// rvalid rises together with the registered rd_data
	always_ff @(posedge clk) begin
		if (!resetn)
			rvalid_q <= 1'b0;
		else if (rd_en)
			rvalid_q <= 1'b1;
		else if (s_axi_rready)
			rvalid_q <= 1'b0;
	end

	assign s_axi_awready = wr_ready_q;
	assign s_axi_wready = wr_ready_q;
	assign s_axi_bvalid = bvalid_q;
	assign s_axi_bresp = RESP_OKAY;
	assign s_axi_arready = arready_q;
	assign s_axi_rvalid = rvalid_q;
	// reg_bank holds rd_data until the next rd_en
	assign s_axi_rdata = rd_data;
	assign s_axi_rresp = RESP_OKAY;

	// register write exactly in the cycle of the aw/w handshake
	assert property (@(posedge clk) disable iff (!resetn)
		wr_en == (s_axi_awready && s_axi_wready));

	// write response is held until the master takes it
	assert property (@(posedge clk) disable iff (!resetn)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

	// read data is held until the master takes it
	assert property (@(posedge clk) disable iff (!resetn)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid);

	// a pending read response blocks new read addresses
	assert property (@(posedge clk) disable iff (!resetn)
		$rose(s_axi_arready) |-> !s_axi_rvalid);

endmodule

//--- reg_bank.sv
`timescale 1ns/100ps

module reg_bank (
	input  logic                  clk,
	input  logic                  resetn,
	// strobes from the bridge
	input  logic                  rd_en,
	input  regctl_pkg::reg_idx_t  rd_idx,
	input  logic                  wr_en,
	input  regctl_pkg::reg_idx_t  wr_idx,
	input  regctl_pkg::reg_data_t wr_data,
	output regctl_pkg::reg_data_t rd_data,
	// counter control and value
	output logic                  count_en,
	output logic                  load,
	output regctl_pkg::reg_data_t load_value,
	input  regctl_pkg::reg_data_t count
);
	import regctl_pkg::*;

	reg_data_t scratch [NUM_SCRATCH];
	// control register bit 0
	logic ctrl_en;
	// offsets into the scratch array, wrap high below the base
	reg_idx_t wr_off;
	reg_idx_t rd_off;
	logic wr_scratch;
	logic rd_scratch;
	// word selected for the current read
	reg_data_t rd_word;

	assign wr_off = wr_idx - REG_SCRATCH_BASE;
	assign rd_off = rd_idx - REG_SCRATCH_BASE;
	// one unsigned compare covers both ends of the window
	assign wr_scratch = wr_off < reg_idx_t'(NUM_SCRATCH);
	assign rd_scratch = rd_off < reg_idx_t'(NUM_SCRATCH);

	always_ff @(posedge clk) begin
		if (!resetn)
			ctrl_en <= 1'b0;
		else if (wr_en && wr_idx == REG_CTRL)
			ctrl_en <= wr_data[0];
	end

	always_ff @(posedge clk) begin
		if (wr_en && wr_scratch)
			scratch[wr_off[$clog2(NUM_SCRATCH)-1:0]] <= wr_data;
	end

	assign count_en = ctrl_en;
	// counter preset rides on the write strobe itself
	assign load = wr_en && wr_idx == REG_COUNT;
	assign load_value = wr_data;

	// read select, unmapped words give zero
	always_comb begin
		rd_word = '0;
		case (rd_idx)
			REG_ID:
				rd_word = ID_VALUE;
			REG_CTRL:
				rd_word[0] = ctrl_en;
			REG_COUNT:
				rd_word = count;
			default: begin
				if (rd_scratch)
					rd_word = scratch[rd_off[$clog2(NUM_SCRATCH)-1:0]];
			end
		endcase
	end

	// captured at the end of the rd_en cycle, held until the next read
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= rd_word;
	end

	// without a bus write the counter only steps by its enable
	assert property (@(posedge clk) disable iff (!resetn)
		!wr_en |=> count == $past(count) + $past(count_en));

endmodule

//--- event_counter.sv
`timescale 1ns/100ps

module event_counter (
	input  logic                  clk,
	input  logic                  resetn,
	// level, counts every cycle while high
	input  logic                  count_en,
	// single cycle preset request
	input  logic                  load,
	input  regctl_pkg::reg_data_t load_value,
	output regctl_pkg::reg_data_t count
);

	// preset has priority over counting
	// wraps to zero after all ones
	always_ff @(posedge clk) begin
		if (!resetn)
			count <= '0;
		else if (load)
			count <= load_value;
		else if (count_en)
			count <= count + 1'b1;
	end

endmodule

//--- regctl_pkg.sv
package regctl_pkg;

	// axi address width, covers 256 words
	localparam int ADDR_W = 10;
	// register and bus data width
	localparam int DATA_W = 32;
	// word index, taken from address bits 9..2
	localparam int IDX_W = 8;

	typedef logic [ADDR_W-1:0] axi_addr_t;
	typedef logic [DATA_W-1:0] reg_data_t;
	typedef logic [IDX_W-1:0] reg_idx_t;
	typedef logic [1:0] axi_resp_t;

	// register map in word indices
	// read-only identity word
	localparam reg_idx_t REG_ID = 8'd0;
	// bit 0 enables the event counter
	localparam reg_idx_t REG_CTRL = 8'd1;
	// counter value, a write presets it
	localparam reg_idx_t REG_COUNT = 8'd2;
	// index 3 is left unmapped
	localparam reg_idx_t REG_SCRATCH_BASE = 8'd4;
	// scratch words sit at 4..11
	localparam int NUM_SCRATCH = 8;

	// "REG1" in ascii
	localparam reg_data_t ID_VALUE = 32'h5245_4731;

	// only OKAY is ever returned
	localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage
